// ==== rtl/ctrl_bus_pkg.sv ====
package ctrl_bus_pkg;

    // bus geometry
    localparam int ADDR_WIDTH  = 22;
    localparam int DATA_WIDTH  = 32;
    localparam int SEL_WIDTH   = DATA_WIDTH / 8;
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 5;

    // master positions in the grant vector
    localparam int MST_GTP = 0;
    localparam int MST_DBG = 1;

    // slave slot numbers, slot field is adr[14:12]
    localparam int SLOT_ID_CTRL = 0;
    localparam int SLOT_RAM0    = 1;
    localparam int SLOT_RAM1    = 2;
    localparam int SLOT_RAM2    = 3;
    localparam int SLOT_EXT     = 4;

    // master to slave, 61 bits
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0] dat;
        logic [SEL_WIDTH-1:0]  sel;
    } wb_req_t;

    // slave to master, 35 bits
    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic                  rty;
        logic [DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    // address map: a slot matches when (adr & ~mask) == base
    // id/ctrl and ext compare bits 14:12, the rams only 13:12 so they show up twice
    localparam logic [ADDR_WIDTH-1:0] ID_CTRL_BASE = 22'h000000;
    localparam logic [ADDR_WIDTH-1:0] ID_CTRL_MASK = 22'h3F8FFF;
    localparam logic [ADDR_WIDTH-1:0] RAM0_BASE    = 22'h001000;
    localparam logic [ADDR_WIDTH-1:0] RAM1_BASE    = 22'h002000;
    localparam logic [ADDR_WIDTH-1:0] RAM2_BASE    = 22'h003000;
    localparam logic [ADDR_WIDTH-1:0] RAM_MASK     = 22'h3FCFFF;
    localparam logic [ADDR_WIDTH-1:0] EXT_BASE     = 22'h004000;
    localparam logic [ADDR_WIDTH-1:0] EXT_MASK     = 22'h3F8FFF;

    // per-slot tables, indexed by slot number
    localparam logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] SLOT_BASE =
        {EXT_BASE, RAM2_BASE, RAM1_BASE, RAM0_BASE, ID_CTRL_BASE};
    localparam logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] SLOT_MASK =
        {EXT_MASK, RAM_MASK, RAM_MASK, RAM_MASK, ID_CTRL_MASK};

    // slot 0 register file
    localparam logic [DATA_WIDTH-1:0] BUS_ID      = 32'hCB05_0001;
    localparam logic [11:0]           REG_ID      = 12'h000;
    localparam logic [11:0]           REG_CTRL    = 12'h004;
    localparam logic [11:0]           REG_SCRATCH = 12'h008;
    localparam int                    CTRL_DBG_EN_BIT = 0;
    // debug master enabled out of reset
    localparam logic [DATA_WIDTH-1:0] CTRL_RESET  = DATA_WIDTH'(1) << CTRL_DBG_EN_BIT;

    // scratch ram depth and word address width
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // replace the bytes of old_w that sel marks with those of new_w
    function automatic logic [DATA_WIDTH-1:0] byte_merge(
        input logic [DATA_WIDTH-1:0] old_w,
        input logic [DATA_WIDTH-1:0] new_w,
        input logic [SEL_WIDTH-1:0]  sel
    );
        logic [DATA_WIDTH-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_WIDTH; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/wb_rr_arbiter.sv ====
`timescale 1ns/1ps

module wb_rr_arbiter import ctrl_bus_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [NUM_MASTERS-1:0] cyc_i,
    input  logic                   dbg_en_i,
    output logic [NUM_MASTERS-1:0] gnt_o
);

    // requests that may win a new grant
    logic [NUM_MASTERS-1:0] req;
    logic [NUM_MASTERS-1:0] gnt_q;
    logic [NUM_MASTERS-1:0] gnt_next;
    // 1 when dbg held the last grant
    logic                   last_q;

    // dbg only competes while the control register enables it
    always_comb begin
        req          = cyc_i;
        req[MST_DBG] = cyc_i[MST_DBG] & dbg_en_i;
    end

    // round robin pick: on a tie the master after the last one wins
    always_comb begin
        gnt_next = '0;
        if (&req) begin
            gnt_next[!last_q] = 1'b1;
        end else begin
            gnt_next = req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gnt_q  <= '0;
            // pretend dbg went last so gtp wins the first tie
            last_q <= 1'b1;
        end else if (|gnt_q) begin
            // hold on raw cyc, a live cycle is never cut by dbg_en
            if (!(|(gnt_q & cyc_i))) begin
                gnt_q <= '0;
            end
        end else if (|req) begin
            gnt_q  <= gnt_next;
            last_q <= gnt_next[MST_DBG];
        end
    end

    assign gnt_o = gnt_q;

endmodule

// ==== rtl/wb_intercon.sv ====
`timescale 1ns/1ps

module wb_intercon import ctrl_bus_pkg::*; (
    input  logic [NUM_MASTERS-1:0] gnt_i,
    input  wb_req_t                gtp_req_i,
    input  wb_req_t                dbg_req_i,
    output wb_rsp_t                gtp_rsp_o,
    output wb_rsp_t                dbg_rsp_o,
    output wb_req_t                slv_req_o [NUM_SLAVES],
    input  wb_rsp_t                slv_rsp_i [NUM_SLAVES]
);

    // shared bus after the master mux
    wb_req_t               m_req;
    // response of the decoded slot
    wb_rsp_t               s_rsp;
    // one-hot, the map covers every slot field value
    logic [NUM_SLAVES-1:0] slot_sel;

    // strobes go only to the granted master, data goes to both
    function automatic wb_rsp_t route_rsp(input wb_rsp_t rsp, input logic gnt);
        wb_rsp_t r;
        r     = rsp;
        r.ack = rsp.ack & gnt;
        r.err = rsp.err & gnt;
        r.rty = rsp.rty & gnt;
        return r;
    endfunction

    // grant is one-hot or zero
    // with no grant the bus idles with cyc and stb low
    always_comb begin
        m_req = '0;
        if (gnt_i[MST_DBG]) begin
            m_req = dbg_req_i;
        end else if (gnt_i[MST_GTP]) begin
            m_req = gtp_req_i;
        end
    end

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slot
        // bits outside the mask select the slot
        assign slot_sel[i] = (m_req.adr & ~SLOT_MASK[i]) == SLOT_BASE[i];

        // slave sees its offset only, strobes gated by decode
        assign slv_req_o[i] = '{
            cyc: m_req.cyc & slot_sel[i],
            stb: m_req.stb & slot_sel[i],
            we:  m_req.we,
            adr: m_req.adr & SLOT_MASK[i],
            dat: m_req.dat,
            sel: m_req.sel
        };
    end

    // response mux
    // unselected slaves are idle so their strobes would be low anyway
    always_comb begin
        s_rsp = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (slot_sel[i]) begin
                s_rsp = slv_rsp_i[i];
            end
        end
    end

    assign gtp_rsp_o = route_rsp(s_rsp, gnt_i[MST_GTP]);
    assign dbg_rsp_o = route_rsp(s_rsp, gnt_i[MST_DBG]);

endmodule

// ==== rtl/id_ctrl_regs.sv ====
`timescale 1ns/1ps

module id_ctrl_regs import ctrl_bus_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o,
    output logic    dbg_en_o
);

    logic [DATA_WIDTH-1:0] ctrl_q;
    logic [DATA_WIDTH-1:0] scratch_q;
    logic [DATA_WIDTH-1:0] rd_dat;
    logic [DATA_WIDTH-1:0] dat_q;
    logic                  ack_q;
    // new strobe, not yet acked
    logic                  strobe;
    // word-aligned register offset
    logic [11:0]           offset;

    assign strobe = req_i.cyc & req_i.stb & ~ack_q;
    assign offset = {req_i.adr[11:2], 2'b00};

    // read decode, holes read back zero
    always_comb begin
        case (offset)
            REG_ID:      rd_dat = BUS_ID;
            REG_CTRL:    rd_dat = ctrl_q;
            REG_SCRATCH: rd_dat = scratch_q;
            default:     rd_dat = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            ctrl_q <= CTRL_RESET;
        end else begin
            // single-cycle ack per strobe
            ack_q <= strobe;
            if (strobe && req_i.we && offset == REG_CTRL) begin
                ctrl_q <= byte_merge(ctrl_q, req_i.dat, req_i.sel);
            end
        end
    end

    // read data and scratch word
    // writes to REG_ID and holes fall through here and are dropped
    always_ff @(posedge clk_i) begin
        if (strobe) begin
            dat_q <= rd_dat;
            if (req_i.we && offset == REG_SCRATCH) begin
                scratch_q <= byte_merge(scratch_q, req_i.dat, req_i.sel);
            end
        end
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, rty: 1'b0, dat: dat_q};

    // arbiter gate for the dbg master
    assign dbg_en_o = ctrl_q[CTRL_DBG_EN_BIT];

endmodule

// ==== rtl/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import ctrl_bus_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
    logic [DATA_WIDTH-1:0] dat_q;
    logic [RAM_AW-1:0]     word;
    logic                  ack_q;
    logic                  strobe;

    // byte address to word index, adr[11:2]
    assign word   = req_i.adr[RAM_AW+1:2];
    assign strobe = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
        end
    end

    // per-byte write enables so the array maps onto byte-write block ram
    // a read during a write returns the old word
    always_ff @(posedge clk_i) begin
        if (strobe) begin
            dat_q <= mem[word];
            if (req_i.we) begin
                for (int b = 0; b < SEL_WIDTH; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, rty: 1'b0, dat: dat_q};

endmodule

// ==== rtl/ctrl_bus_top.sv ====
`timescale 1ns/1ps

module ctrl_bus_top import ctrl_bus_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t gtp_req_i,
    output wb_rsp_t gtp_rsp_o,
    input  wb_req_t dbg_req_i,
    output wb_rsp_t dbg_rsp_o,
    output wb_req_t ext_req_o,
    input  wb_rsp_t ext_rsp_i
);

    logic [NUM_MASTERS-1:0] cyc;
    logic [NUM_MASTERS-1:0] gnt;
    logic                   dbg_en;
    wb_req_t                slv_req [NUM_SLAVES];
    wb_rsp_t                slv_rsp [NUM_SLAVES];

    // arbiter sees each master's cyc as its request
    assign cyc[MST_GTP] = gtp_req_i.cyc;
    assign cyc[MST_DBG] = dbg_req_i.cyc;

    wb_rr_arbiter u_arbiter (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .cyc_i    (cyc),
        .dbg_en_i (dbg_en),
        .gnt_o    (gnt)
    );

    wb_intercon u_intercon (
        .gnt_i     (gnt),
        .gtp_req_i (gtp_req_i),
        .dbg_req_i (dbg_req_i),
        .gtp_rsp_o (gtp_rsp_o),
        .dbg_rsp_o (dbg_rsp_o),
        .slv_req_o (slv_req),
        .slv_rsp_i (slv_rsp)
    );

    // slot 0, also supplies the dbg enable back to the arbiter
    id_ctrl_regs u_regs (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (slv_req[SLOT_ID_CTRL]),
        .rsp_o    (slv_rsp[SLOT_ID_CTRL]),
        .dbg_en_o (dbg_en)
    );

    scratch_ram u_ram0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (slv_req[SLOT_RAM0]),
        .rsp_o   (slv_rsp[SLOT_RAM0])
    );

    scratch_ram u_ram1 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (slv_req[SLOT_RAM1]),
        .rsp_o   (slv_rsp[SLOT_RAM1])
    );

    scratch_ram u_ram2 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (slv_req[SLOT_RAM2]),
        .rsp_o   (slv_rsp[SLOT_RAM2])
    );

    // slot 4 goes off chip, rty from there is relayed as is
    assign ext_req_o         = slv_req[SLOT_EXT];
    assign slv_rsp[SLOT_EXT] = ext_rsp_i;

endmodule

// ==== tests/ctrl_bus_assertions.sv ====
`timescale 1ns/1ps

module ctrl_bus_assertions import ctrl_bus_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [NUM_MASTERS-1:0] gnt_i,
    input  wb_req_t                gtp_req_i,
    input  wb_req_t                dbg_req_i,
    input  wb_rsp_t                gtp_rsp_i,
    input  wb_rsp_t                dbg_rsp_i,
    input  wb_req_t                slv_req_i [NUM_SLAVES]
);

    // stb of every slave slot, gathered into one vector
    logic [NUM_SLAVES-1:0] slv_stb;
    // number of assertion failures so far, the testbench polls it
    int unsigned           fail_count = 0;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            slv_stb[i] = slv_req_i[i].stb;
        end
    end

    // at most one master owns the bus
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_i))
        else begin
            $error("grant vector has more than one bit set");
            fail_count++;
        end

    // a master only sees ack inside its own cycle
    a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        !(gtp_rsp_i.ack && !gtp_req_i.cyc) && !(dbg_rsp_i.ack && !dbg_req_i.cyc))
        else begin
            $error("ack seen by a master with cyc low");
            fail_count++;
        end

    // ack and err are exclusive terminations
    a_ack_err: assert property (@(posedge clk_i) disable iff (reset_i)
        !(gtp_rsp_i.ack && gtp_rsp_i.err) && !(dbg_rsp_i.ack && dbg_rsp_i.err))
        else begin
            $error("ack and err high in the same cycle");
            fail_count++;
        end

    // slot decode is one-hot, so only one slave is strobed
    a_slv_stb: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(slv_stb))
        else begin
            $error("more than one slave stb high");
            fail_count++;
        end

endmodule

bind ctrl_bus_top ctrl_bus_assertions u_checks (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .gnt_i     (gnt),
    .gtp_req_i (gtp_req_i),
    .dbg_req_i (dbg_req_i),
    .gtp_rsp_i (gtp_rsp_o),
    .dbg_rsp_i (dbg_rsp_o),
    .slv_req_i (slv_req)
);

// ==== tests/tb_ctrl_bus.sv ====
`timescale 1ns/1ps

module tb_ctrl_bus import ctrl_bus_pkg::*; ();

    // about 200 transactions at under 25 cycles each
    localparam int TXN_BUDGET     = 200;
    localparam int TXN_CYCLES     = 25;
    localparam int TIMEOUT_CYCLES = TXN_BUDGET * TXN_CYCLES;

    logic        clk_i = 1'b0;
    logic        reset_i;
    wb_req_t     gtp_req;
    wb_req_t     dbg_req;
    wb_rsp_t     gtp_rsp;
    wb_rsp_t     dbg_rsp;
    wb_req_t     ext_req;
    wb_rsp_t     ext_rsp = '0;
    logic [31:0] lfsr_state = 32'h2832_e27f;
    // expected contents of the first 16 words of each ram
    logic [31:0] shadow [3][16];
    logic [21:0] ext_last_adr;
    logic [31:0] ext_last_dat;
    logic        ext_last_we;
    logic [3:0]  ext_last_sel;
    int          ext_hits = 0;
    int          cycle_cnt = 0;
    logic        dbg_done;

    ctrl_bus_top UUT (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .gtp_req_i (gtp_req),
        .gtp_rsp_o (gtp_rsp),
        .dbg_req_i (dbg_req),
        .dbg_rsp_o (dbg_rsp),
        .ext_req_o (ext_req),
        .ext_rsp_i (ext_rsp)
    );

    always #10 clk_i = ~clk_i;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // ram word address, random upper bits and random shadow alias in bit 14
    function automatic logic [21:0] ram_addr(input int r, input int w);
        return {7'(rand_bits(7)), 1'(rand_bits(1)), 2'(r + 1), 10'(w), 2'b00};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one single cycle on the bus, held until ack or err
    task automatic xfer(input int m, input logic we, input logic [21:0] adr,
                        input logic [31:0] dat, input logic [3:0] sel,
                        output logic [31:0] rdat, output logic err);
        wb_req_t req;
        wb_rsp_t rsp;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        @(posedge clk_i);
        if (m == MST_DBG) begin
            dbg_req <= req;
        end else begin
            gtp_req <= req;
        end
        do begin
            @(posedge clk_i);
            rsp = (m == MST_DBG) ? dbg_rsp : gtp_rsp;
        end while (!(rsp.ack || rsp.err));
        if (m == MST_DBG) begin
            dbg_req <= '0;
        end else begin
            gtp_req <= '0;
        end
        rdat = rsp.dat;
        err  = rsp.err;
    endtask

    // masked write, then read back through a fresh alias
    task automatic ram_access(input int m, input int r, input int w, input logic [3:0] sel);
        logic [31:0] dat;
        logic [31:0] mask;
        logic [31:0] rd;
        logic        er;
        dat  = rand_bits(32);
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        xfer(m, 1'b1, ram_addr(r, w), dat, sel, rd, er);
        shadow[r][w] = (shadow[r][w] & ~mask) | (dat & mask);
        xfer(m, 1'b0, ram_addr(r, w), '0, 4'hF, rd, er);
        check_eq("ram rsp dat", rd, shadow[r][w]);
    endtask

    // external slave, acks a cycle after stb, err at offset 0xFFC
    always @(posedge clk_i) begin
        if (reset_i) begin
            ext_rsp <= '0;
        end else if (ext_req.cyc && ext_req.stb && !ext_rsp.ack && !ext_rsp.err) begin
            ext_rsp.ack  <= ext_req.adr[11:0] != 12'hFFC;
            ext_rsp.err  <= ext_req.adr[11:0] == 12'hFFC;
            ext_rsp.dat  <= 32'hEE00_0000 + 32'(ext_req.adr[11:0]);
            ext_hits     <= ext_hits + 1;
            ext_last_adr <= ext_req.adr;
            ext_last_dat <= ext_req.dat;
            ext_last_we  <= ext_req.we;
            ext_last_sel <= ext_req.sel;
        end else begin
            ext_rsp <= '0;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("simulation timed out waiting for a bus response");
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // bound protocol checks raise the tally, stop at the first one
    always @(negedge clk_i) begin
        if (UUT.u_checks.fail_count != 0) begin
            $display("a bus protocol assertion failed");
            $display("TEST FAIL");
            $fatal(1, "protocol assertion");
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic        er;
        reset_i = 1'b1;
        gtp_req = '0;
        dbg_req = '0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        // id is read-only, scratch merges bytes
        xfer(MST_GTP, 1'b0, 22'(REG_ID), '0, 4'hF, rd, er);
        check_eq("gtp id dat", rd, BUS_ID);
        xfer(MST_DBG, 1'b0, 22'(REG_ID), '0, 4'hF, rd, er);
        check_eq("dbg id dat", rd, BUS_ID);
        xfer(MST_GTP, 1'b1, 22'(REG_ID), 32'h1234_5678, 4'hF, rd, er);
        xfer(MST_GTP, 1'b0, 22'(REG_ID), '0, 4'hF, rd, er);
        check_eq("id after write", rd, BUS_ID);
        a = rand_bits(32);
        b = rand_bits(32);
        xfer(MST_GTP, 1'b1, 22'(REG_SCRATCH), a, 4'hF, rd, er);
        xfer(MST_DBG, 1'b1, 22'(REG_SCRATCH), b, 4'b0101, rd, er);
        xfer(MST_GTP, 1'b0, 22'(REG_SCRATCH), '0, 4'hF, rd, er);
        check_eq("scratch dat", rd, {a[31:24], b[23:16], a[15:8], b[7:0]});

        // fill words 0..7 of each ram, then random masked traffic
        for (int r = 0; r < 3; r++) begin
            for (int w = 0; w < 8; w++) begin
                ram_access(MST_GTP, r, w, 4'hF);
            end
        end
        for (int i = 0; i < 40; i++) begin
            ram_access(int'(rand_bits(1)), int'(rand_bits(8) % 3), int'(rand_bits(3)),
                       4'(rand_bits(4)));
        end

        // both masters at once on separate words
        fork
            for (int i = 0; i < 4; i++) begin
                ram_access(MST_GTP, 1, 8 + i, 4'hF);
            end
            for (int i = 0; i < 4; i++) begin
                ram_access(MST_DBG, 2, 8 + i, 4'hF);
            end
        join

        // dbg stalls while dbg_en is clear
        xfer(MST_GTP, 1'b1, 22'(REG_CTRL), 32'h0, 4'h1, rd, er);
        dbg_done = 1'b0;
        fork
            begin
                ram_access(MST_DBG, 0, 0, 4'hF);
                dbg_done = 1'b1;
            end
        join_none
        for (int i = 0; i < 3; i++) begin
            ram_access(MST_GTP, 1 + i % 2, i, 4'hF);
        end
        check_eq("dbg_done", 32'(dbg_done), 32'h0);
        xfer(MST_GTP, 1'b1, 22'(REG_CTRL), 32'h1, 4'h1, rd, er);
        wait (dbg_done == 1'b1);

        // external slot sees the masked address, write data, we and sel
        a = rand_bits(32);
        xfer(MST_GTP, 1'b1, 22'h004120, a, 4'h6, rd, er);
        check_eq("ext_req adr", 32'(ext_last_adr), 32'h0000_0120);
        check_eq("ext_req dat", ext_last_dat, a);
        check_eq("ext_req we", 32'(ext_last_we), 32'h1);
        check_eq("ext_req sel", 32'(ext_last_sel), 32'h6);
        xfer(MST_DBG, 1'b0, 22'h004AB8, '0, 4'hF, rd, er);
        check_eq("dbg ext dat", rd, 32'hEE00_0AB8);
        check_eq("dbg ext err", 32'(er), 32'h0);
        check_eq("ext_req we", 32'(ext_last_we), 32'h0);
        xfer(MST_GTP, 1'b0, 22'h004FFC, '0, 4'hF, rd, er);
        check_eq("gtp ext err", 32'(er), 32'h1);
        check_eq("ext strobe count", 32'(ext_hits), 32'h3);

        repeat (2) @(posedge clk_i);
        if (UUT.u_checks.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "protocol assertion");
        end
    end

endmodule

// ==== filelist.f ====
rtl/ctrl_bus_pkg.sv
rtl/wb_rr_arbiter.sv
rtl/wb_intercon.sv
rtl/id_ctrl_regs.sv
rtl/scratch_ram.sv
rtl/ctrl_bus_top.sv
tests/ctrl_bus_assertions.sv
tests/tb_ctrl_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_ctrl_bus with verilator, run it, and search the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ctrl_bus \
    -f filelist.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
